// File: uart_stim.txt
// op sel data expected: 1 write, 2 read, 3 status, 4 output, 5 scratch, 6 push, 7 rx data
// 8 pulse count since last clear (a), sel 0 push 1 divload 2 rxflush 3 txflush 4 load
40000003
22000001
133B0000
2300003B
4200003B
11070000
21000007
43000007
14100000
24000010
44000001
17A50000
270000A5
50000000
50000000
A0000000
13830000
10340000
47000001
11120000
47000001
41001234
20000034
21000012
80000000
81000002
13030000
705A0000
2000005A
21000007
A0000000
10550000
47000000
10660000
80000002
81000000
12010000
40000000
46000001
220000C1
A0000000
12070000
82000001
83000001
40000000
A0000000
12030000
82000001
83000000
30010000
A0000000
60050002
45000001
25000084
25000000
45000000
84000001
30010000
A0000000
30030000
30010000
84000000
45000001
25000002
45000000
26000000
28000000
2F000000
48000000
00000000

// File: build.f
+incdir+.
uart_pkg.sv
uart_bus_decode.sv
uart_ctrl_regs.sv
uart_line_status.sv
uart_read_mux.sv
uart_regs_top.sv
uart_regs_assert.sv
tb_uart_regs.sv

// File: Bender.yml
package:
  name: uart_regs

export_include_dirs:
  - .

sources:
  - files:
      - uart_pkg.sv
      - uart_bus_decode.sv
      - uart_ctrl_regs.sv
      - uart_line_status.sv
      - uart_read_mux.sv
      - uart_regs_top.sv
  - target: test
    files:
      - uart_regs_assert.sv
      - tb_uart_regs.sv

// File: tb_uart_regs.sv
// Testbench for the UART host register block
// Runs the operations in uart_stim.txt from the project root, one 32-bit word each
// Word layout: op[31:28] sel[27:24] data[23:16] expected[15:0]; op 0 ends the run
// Outputs are sampled on the falling edge, inputs change on the rising edge
`timescale 1ns/1ns
`include "uart_config.svh"

module tb_uart_regs;

    localparam int CLK_HALF  = 2;                   // 4 ns period
    localparam int TIMEOUT   = 50;                  // Cycles per wait
    localparam int STIM_SIZE = 128;

    logic                    WBs_CLK_i;
    logic                    WBs_RST_i;
    logic [`UART_ADDR_W-1:0] WBs_ADR_i;
    logic                    WBs_CYC_i, WBs_STB_i, WBs_WE_i;
    uart_pkg::bus_data_t     WBs_DAT_i;
    uart_pkg::rd_data_t      WBs_DAT_o;
    logic                    WBs_ACK_o;
    logic Tx_FIFO_Flush_o, Tx_FIFO_Push_o, Tx_Clock_Divisor_Load_o, Tx_Break_Control_o;
    uart_pkg::divisor_t      Tx_Clock_Divisor_o;
    logic Tx_Storage_Empty_i, Tx_Logic_Empty_i;
    logic Rx_FIFO_Empty_i, Rx_FIFO_Flush_o, Rx_FIFO_Push_i, Rx_FIFO_Pop_o;
    uart_pkg::bus_data_t     Rx_FIFO_DAT_i;
    logic Rx_Data_Ready_i, Rx_Overrun_Error_i, Rx_Parity_Error_i, Rx_Framing_Error_i;
    logic Rx_Break_Interrupt_i, Rx_Line_Status_Load_o;
    logic Rx_Tx_FIFO_Enable_o, Rx_Tx_Number_of_Stop_Bits_o, Rx_Tx_Enable_Parity_o;
    logic Rx_Tx_Even_Parity_Select_o, Rx_Tx_Sticky_Parity_o, Rx_Tx_Loop_Back_o;
    logic [1:0] Rx_Tx_Word_Length_Select_o, Rx_Trigger_o;
    logic       Interrupt_Pending_i;
    logic [2:0] Interrupt_Identification_i;
    logic Enable_Rx_Data_Avail_Intr_o, Enable_Tx_Holding_Reg_Empty_Intr_o;
    logic Enable_Rx_Line_Status_Intr_o, Line_Status_Intr_o, UART_16550_IIR_Rd_o;

    logic [31:0] stim [0:STIM_SIZE-1];
    integer      seed;
    int          pulse_cnt [0:4];                   // push, div load, rx flush, tx flush, load
    int          pulse_base [0:4];                  // Snapshot at last clear
    logic        last_div_load;                     // Load pulse seen after last write ACK
    logic        dlab_set;                          // Model of LCR bit 7

    uart_regs_top dut0 (.*);

    initial
    begin
        WBs_CLK_i = 1'b0;
        forever
            #CLK_HALF WBs_CLK_i = ~WBs_CLK_i;
    end

    // Pulse counters ------------------------------------
    always @(negedge WBs_CLK_i)
    begin
        if (!WBs_RST_i)
        begin
            pulse_cnt[0] <= pulse_cnt[0] + int'(Tx_FIFO_Push_o);
            pulse_cnt[1] <= pulse_cnt[1] + int'(Tx_Clock_Divisor_Load_o);
            pulse_cnt[2] <= pulse_cnt[2] + int'(Rx_FIFO_Flush_o);
            pulse_cnt[3] <= pulse_cnt[3] + int'(Tx_FIFO_Flush_o);
            pulse_cnt[4] <= pulse_cnt[4] + int'(Rx_Line_Status_Load_o);
        end
    end

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    // A failing property in the bound checker ends the run
    always @(negedge WBs_CLK_i)
    begin
        if (dut0.u_assert.prop_failed === 1'b1)
            stop_run("a protocol assertion in the bound checker failed");
    end

    // Compares a result and stops at the first mismatch
    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s expected %h actual %h", name, exp, act);
            stop_run("first mismatch ends the run");
        end
    endtask

    // Waits on the falling edge until ACK, then releases the strobe
    task automatic wait_ack(input string what);
        int n;
        n = 0;
        @(negedge WBs_CLK_i);
        while (WBs_ACK_o !== 1'b1)
        begin
            n++;
            if (n > TIMEOUT)
                stop_run({"no ACK came for the ", what});
            @(negedge WBs_CLK_i);
        end
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [7:0] dat);
        @(posedge WBs_CLK_i);
        WBs_ADR_i <= adr;
        WBs_DAT_i <= dat;
        WBs_WE_i  <= 1'b1;
        WBs_CYC_i <= 1'b1;
        WBs_STB_i <= 1'b1;
        wait_ack("write");
        @(posedge WBs_CLK_i);
        WBs_CYC_i <= 1'b0;
        WBs_STB_i <= 1'b0;
        WBs_WE_i  <= 1'b0;
        @(negedge WBs_CLK_i);
        last_div_load = Tx_Clock_Divisor_Load_o;    // One cycle after the ACK cycle
        check("ack_width_wr", 16'h0, {15'h0, WBs_ACK_o});
        if (adr == `UART_ADR_LCR)
            dlab_set = dat[`UART_LCR_DLAB_BIT];     // Banks addresses 0 and 1
        if (adr == `UART_ADR_IIR_FCR)
            check("rx_trigger", {14'h0, dat[7:6]}, {14'h0, Rx_Trigger_o});
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [15:0] dat);
        logic exp_pop;
        logic exp_iir;
        @(posedge WBs_CLK_i);
        WBs_ADR_i <= adr;
        WBs_WE_i  <= 1'b0;
        WBs_CYC_i <= 1'b1;
        WBs_STB_i <= 1'b1;
        wait_ack("read");
        dat = WBs_DAT_o;                            // Valid while ACK is high
        @(posedge WBs_CLK_i);
        WBs_CYC_i <= 1'b0;
        WBs_STB_i <= 1'b0;
        @(negedge WBs_CLK_i);
        check("ack_width_rd", 16'h0, {15'h0, WBs_ACK_o});
        // Pop and IIR-read pulses sit one cycle after the ACK cycle
        exp_pop = (adr == `UART_ADR_RBR_THR_DLL) && !dlab_set;
        exp_iir = (adr == `UART_ADR_IIR_FCR);
        check("rx_pop", {15'h0, exp_pop}, {15'h0, Rx_FIFO_Pop_o});
        check("iir_rd", {15'h0, exp_iir}, {15'h0, UART_16550_IIR_Rd_o});
    endtask

    // Status byte: empty, overrun, parity, framing, break, ready, tx storage, tx logic
    task automatic set_status(input logic [7:0] s);
        Rx_FIFO_Empty_i      <= s[0];
        Rx_Overrun_Error_i   <= s[1];
        Rx_Parity_Error_i    <= s[2];
        Rx_Framing_Error_i   <= s[3];
        Rx_Break_Interrupt_i <= s[4];
        Rx_Data_Ready_i      <= s[5];
        Tx_Storage_Empty_i   <= s[6];
        Tx_Logic_Empty_i     <= s[7];
    endtask

    // Pushes one word and counts the cycles until the line-status load pulse
    task automatic push_and_time(input logic [7:0] s, input logic [15:0] exp);
        int n;
        n = 0;
        @(posedge WBs_CLK_i);
        set_status(s);
        Rx_FIFO_Push_i <= 1'b1;
        @(posedge WBs_CLK_i);
        Rx_FIFO_Push_i <= 1'b0;
        n = 1;
        @(negedge WBs_CLK_i);
        while (Rx_Line_Status_Load_o !== 1'b1)
        begin
            if (n > TIMEOUT)
                stop_run("line status load pulse never appeared");
            @(posedge WBs_CLK_i);
            n++;
            @(negedge WBs_CLK_i);
        end
        check("load_delay", exp, 16'(n));
        @(negedge WBs_CLK_i);                       // Errors latch on the clock ending the load
    endtask

    function automatic logic [15:0] output_sel(input logic [3:0] sel);
        case (sel)
            4'h0: return {14'h0, Rx_FIFO_Flush_o, Tx_FIFO_Flush_o};
            4'h1: return Tx_Clock_Divisor_o;
            4'h2: return {9'h0, Tx_Break_Control_o, Rx_Tx_Sticky_Parity_o,
                          Rx_Tx_Even_Parity_Select_o, Rx_Tx_Enable_Parity_o,
                          Rx_Tx_Number_of_Stop_Bits_o, Rx_Tx_Word_Length_Select_o};
            4'h3: return {13'h0, Enable_Rx_Line_Status_Intr_o,
                          Enable_Tx_Holding_Reg_Empty_Intr_o, Enable_Rx_Data_Avail_Intr_o};
            4'h4: return {15'h0, Rx_Tx_Loop_Back_o};
            4'h5: return {15'h0, Line_Status_Intr_o};
            4'h6: return {15'h0, Rx_Tx_FIFO_Enable_o};
            4'h7: return {15'h0, last_div_load};
            4'h8: return {15'h0, WBs_ACK_o};
            default: return 16'hdead;
        endcase
    endfunction

    // Main sequence ------------------------------------
    initial
    begin
        logic [15:0] rd;
        logic [31:0] w;
        logic [7:0]  rnd;
        string       tag;

        seed = 32'had23_2afc;
        last_div_load = 1'b0;
        dlab_set = 1'b0;
        for (int i = 0; i < 5; i++)
        begin
            pulse_cnt[i]  = 0;
            pulse_base[i] = 0;
        end
        for (int i = 0; i < STIM_SIZE; i++)
            stim[i] = 32'h0;
        $readmemh("uart_stim.txt", stim);

        WBs_RST_i <= 1'b1;
        WBs_ADR_i <= '0;
        WBs_CYC_i <= 1'b0;
        WBs_STB_i <= 1'b0;
        WBs_WE_i  <= 1'b0;
        WBs_DAT_i <= '0;
        Rx_FIFO_Push_i <= 1'b0;
        Rx_FIFO_DAT_i  <= '0;
        Interrupt_Pending_i <= 1'b1;                // IIR reads as no interrupt pending
        Interrupt_Identification_i <= 3'b0;
        set_status(8'h00);
        repeat (8) @(posedge WBs_CLK_i);
        WBs_RST_i <= 1'b0;
        @(negedge WBs_CLK_i);

        for (int i = 0; i < STIM_SIZE; i++)
        begin
            w = stim[i];
            if (w[31:28] == 4'h0 || $isunknown(w))
                break;
            tag = $sformatf("line%0d_op%h_sel%h", i, w[31:28], w[27:24]);
            case (w[31:28])
                4'h1: bus_write(w[27:24], w[23:16]);
                4'h2:
                begin
                    bus_read(w[27:24], rd);
                    check(tag, w[15:0], rd);
                end
                4'h3:
                begin
                    @(posedge WBs_CLK_i);
                    set_status(w[23:16]);
                    @(negedge WBs_CLK_i);
                end
                4'h4: check(tag, w[15:0], output_sel(w[27:24]));
                4'h5:
                begin
                    rnd = 8'($random(seed));        // Scratch byte
                    bus_write(`UART_ADR_SCR, rnd);
                    bus_read(`UART_ADR_SCR, rd);
                    check(tag, {8'h0, rnd}, rd);
                end
                4'h6: push_and_time(w[23:16], w[15:0]);
                4'h7:
                begin
                    @(posedge WBs_CLK_i);
                    Rx_FIFO_DAT_i <= w[23:16];
                    @(negedge WBs_CLK_i);
                end
                4'h8: check(tag, w[15:0], 16'(pulse_cnt[w[26:24]] - pulse_base[w[26:24]]));
                4'ha:
                begin
                    @(negedge WBs_CLK_i);
                    for (int k = 0; k < 5; k++)
                        pulse_base[k] = pulse_cnt[k];
                end
                default: stop_run($sformatf("unknown operation in stim line %0d", i));
            endcase
        end

        if (dut0.u_assert.prop_failed === 1'b1)
            stop_run("a protocol assertion in the bound checker failed");
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: uart_regs_assert.sv
// Protocol assertions for the UART register block, bound to the top level
// All properties are disabled while reset is high
`timescale 1ns/1ns

module uart_regs_assert (
    input  logic WBs_CLK_i,
    input  logic WBs_RST_i,
    input  logic WBs_ACK_o,
    input  logic Rx_FIFO_Pop_o,
    input  logic Tx_Clock_Divisor_Load_o,
    input  logic Rx_FIFO_Flush_o,
    input  logic Tx_FIFO_Flush_o,
    input  logic Rx_Tx_FIFO_Enable_o,
    input  logic fcr_wr_i
);

    logic prop_failed = 1'b0;                       // Set by any failing property

    // ACK is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        WBs_ACK_o |=> !WBs_ACK_o)
        else
        begin
            $error("ACK held high for two cycles");
            prop_failed = 1'b1;
        end

    pop_one_cycle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        Rx_FIFO_Pop_o |=> !Rx_FIFO_Pop_o)
        else
        begin
            $error("Rx pop pulse longer than one cycle");
            prop_failed = 1'b1;
        end

    div_load_one_cycle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        Tx_Clock_Divisor_Load_o |=> !Tx_Clock_Divisor_Load_o)
        else
        begin
            $error("Divisor load pulse longer than one cycle");
            prop_failed = 1'b1;
        end

    // With the FIFO on, a flush only comes from an FCR write
    flush_after_fcr: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        (Rx_Tx_FIFO_Enable_o && (Rx_FIFO_Flush_o || Tx_FIFO_Flush_o)) |-> $past(fcr_wr_i))
        else
        begin
            $error("Flush pulse without a preceding FCR write");
            prop_failed = 1'b1;
        end

endmodule

bind uart_regs_top uart_regs_assert u_assert (
    .WBs_CLK_i(WBs_CLK_i),
    .WBs_RST_i(WBs_RST_i),
    .WBs_ACK_o(WBs_ACK_o),
    .Rx_FIFO_Pop_o(Rx_FIFO_Pop_o),
    .Tx_Clock_Divisor_Load_o(Tx_Clock_Divisor_Load_o),
    .Rx_FIFO_Flush_o(Rx_FIFO_Flush_o),
    .Tx_FIFO_Flush_o(Tx_FIFO_Flush_o),
    .Rx_Tx_FIFO_Enable_o(Rx_Tx_FIFO_Enable_o),
    .fcr_wr_i(fcr_wr)
);

// File: uart_regs_top.sv
// Host register block of a 16550-style UART
// Transmitter, receiver, FIFOs and interrupt controller sit outside this block
// No extended FIFO-level registers and no modem status register
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_regs_top (
    input  logic                    WBs_CLK_i,
    input  logic                    WBs_RST_i,
    input  logic [`UART_ADDR_W-1:0] WBs_ADR_i,
    input  logic                    WBs_CYC_i,
    input  logic                    WBs_STB_i,
    input  logic                    WBs_WE_i,
    input  uart_pkg::bus_data_t     WBs_DAT_i,
    output uart_pkg::rd_data_t      WBs_DAT_o,
    output logic                    WBs_ACK_o,
    // Tx
    output logic                    Tx_FIFO_Flush_o,
    output logic                    Tx_FIFO_Push_o,
    output uart_pkg::divisor_t      Tx_Clock_Divisor_o,
    output logic                    Tx_Clock_Divisor_Load_o,
    input  logic                    Tx_Storage_Empty_i,
    input  logic                    Tx_Logic_Empty_i,
    output logic                    Tx_Break_Control_o,
    // Rx
    input  logic                    Rx_FIFO_Empty_i,
    output logic                    Rx_FIFO_Flush_o,
    input  logic                    Rx_FIFO_Push_i,
    output logic                    Rx_FIFO_Pop_o,
    input  uart_pkg::bus_data_t     Rx_FIFO_DAT_i,
    input  logic                    Rx_Data_Ready_i,
    input  logic                    Rx_Overrun_Error_i,
    input  logic                    Rx_Parity_Error_i,
    input  logic                    Rx_Framing_Error_i,
    input  logic                    Rx_Break_Interrupt_i,
    output logic                    Rx_Line_Status_Load_o,
    // Line control, common to Rx and Tx
    output logic                    Rx_Tx_FIFO_Enable_o,
    output logic [1:0]              Rx_Tx_Word_Length_Select_o,
    output logic                    Rx_Tx_Number_of_Stop_Bits_o,
    output logic                    Rx_Tx_Enable_Parity_o,
    output logic                    Rx_Tx_Even_Parity_Select_o,
    output logic                    Rx_Tx_Sticky_Parity_o,
    output logic                    Rx_Tx_Loop_Back_o,
    // Interrupt
    output logic [1:0]              Rx_Trigger_o,
    input  logic                    Interrupt_Pending_i,
    input  logic [2:0]              Interrupt_Identification_i,
    output logic                    Enable_Rx_Data_Avail_Intr_o,
    output logic                    Enable_Tx_Holding_Reg_Empty_Intr_o,
    output logic                    Enable_Rx_Line_Status_Intr_o,
    output logic                    Line_Status_Intr_o,
    output logic                    UART_16550_IIR_Rd_o
);

    uart_pkg::reg_addr_e bus_adr;
    uart_pkg::bus_data_t lcr;
    uart_pkg::bus_data_t scr;
    logic [2:0]          ier;
    logic [3:0]          lsr_err;                   // Sticky error bits
    logic                dlab, lsr_rd;
    logic                ier_wr, fcr_wr, lcr_wr, mcr_wr, scr_wr, dll_wr, dlm_wr;

    assign bus_adr = uart_pkg::reg_addr_e'(WBs_ADR_i);  // Unmapped codes kept as is

    // Line control fields ------------------------------
    assign Rx_Tx_Word_Length_Select_o  = lcr[1:0];
    assign Rx_Tx_Number_of_Stop_Bits_o = lcr[2];
    assign Rx_Tx_Enable_Parity_o       = lcr[3];
    assign Rx_Tx_Even_Parity_Select_o  = lcr[4];
    assign Rx_Tx_Sticky_Parity_o       = lcr[5];
    assign Tx_Break_Control_o          = lcr[6];    // Holds Tx low
    assign Enable_Rx_Data_Avail_Intr_o        = ier[0];
    assign Enable_Tx_Holding_Reg_Empty_Intr_o = ier[1];
    assign Enable_Rx_Line_Status_Intr_o       = ier[2];

    uart_bus_decode u_decode (
        .WBs_CLK_i, .WBs_RST_i, .adr_i(bus_adr), .cyc_i(WBs_CYC_i), .stb_i(WBs_STB_i),
        .we_i(WBs_WE_i), .dlab_i(dlab), .ack_o(WBs_ACK_o), .thr_wr_o(Tx_FIFO_Push_o),
        .ier_wr_o(ier_wr), .fcr_wr_o(fcr_wr), .lcr_wr_o(lcr_wr), .mcr_wr_o(mcr_wr),
        .scr_wr_o(scr_wr), .dll_wr_o(dll_wr), .dlm_wr_o(dlm_wr), .lsr_rd_o(lsr_rd),
        .rbr_pop_o(Rx_FIFO_Pop_o), .iir_rd_o(UART_16550_IIR_Rd_o),
        .div_load_o(Tx_Clock_Divisor_Load_o)
    );

    uart_ctrl_regs u_regs (
        .WBs_CLK_i, .WBs_RST_i, .dat_i(WBs_DAT_i), .ier_wr_i(ier_wr), .fcr_wr_i(fcr_wr),
        .lcr_wr_i(lcr_wr), .mcr_wr_i(mcr_wr), .scr_wr_i(scr_wr), .dll_wr_i(dll_wr),
        .dlm_wr_i(dlm_wr), .dlab_o(dlab), .ier_o(ier), .fifo_enable_o(Rx_Tx_FIFO_Enable_o),
        .rx_trigger_o(Rx_Trigger_o), .lcr_o(lcr), .loop_back_o(Rx_Tx_Loop_Back_o),
        .scr_o(scr), .divisor_o(Tx_Clock_Divisor_o), .rx_flush_o(Rx_FIFO_Flush_o),
        .tx_flush_o(Tx_FIFO_Flush_o)
    );

    uart_line_status u_lsr (
        .WBs_CLK_i, .WBs_RST_i, .fifo_enable_i(Rx_Tx_FIFO_Enable_o),
        .rx_fifo_empty_i(Rx_FIFO_Empty_i), .rx_fifo_push_i(Rx_FIFO_Push_i),
        .rx_fifo_pop_i(Rx_FIFO_Pop_o), .overrun_i(Rx_Overrun_Error_i),
        .parity_i(Rx_Parity_Error_i), .framing_i(Rx_Framing_Error_i),
        .break_i(Rx_Break_Interrupt_i), .lsr_rd_i(lsr_rd),
        .load_o(Rx_Line_Status_Load_o), .err_o(lsr_err), .intr_o(Line_Status_Intr_o)
    );

    uart_read_mux u_rdmux (
        .adr_i(bus_adr), .dlab_i(dlab), .rx_dat_i(Rx_FIFO_DAT_i),
        .dll_i(Tx_Clock_Divisor_o[`UART_DATA_W-1:0]),
        .dlm_i(Tx_Clock_Divisor_o[2*`UART_DATA_W-1:`UART_DATA_W]),
        .ier_i(ier), .fifo_enable_i(Rx_Tx_FIFO_Enable_o),
        .intr_pending_i(Interrupt_Pending_i), .intr_id_i(Interrupt_Identification_i),
        .lcr_i(lcr), .loop_back_i(Rx_Tx_Loop_Back_o), .scr_i(scr),
        .rx_data_ready_i(Rx_Data_Ready_i), .tx_storage_empty_i(Tx_Storage_Empty_i),
        .tx_logic_empty_i(Tx_Logic_Empty_i), .err_i(lsr_err), .rd_dat_o(WBs_DAT_o)
    );

endmodule

// File: uart_read_mux.sv
// Read data multiplexer
// Combinational on address and register state; upper read byte is always zero
// Address 6 (MSR) and 8 and above read zero
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_read_mux (
    input  uart_pkg::reg_addr_e   adr_i,
    input  logic                  dlab_i,
    input  uart_pkg::bus_data_t   rx_dat_i,
    input  uart_pkg::bus_data_t   dll_i,
    input  uart_pkg::bus_data_t   dlm_i,
    input  logic [2:0]            ier_i,
    input  logic                  fifo_enable_i,
    input  logic                  intr_pending_i,
    input  logic [2:0]            intr_id_i,
    input  uart_pkg::bus_data_t   lcr_i,
    input  logic                  loop_back_i,
    input  uart_pkg::bus_data_t   scr_i,
    input  logic                  rx_data_ready_i,
    input  logic                  tx_storage_empty_i,
    input  logic                  tx_logic_empty_i,
    input  logic [3:0]            err_i,
    output uart_pkg::rd_data_t    rd_dat_o
);

    uart_pkg::bus_data_t rd_byte;
    logic                fifo_data_err;             // LSR bit 7

    assign fifo_data_err = fifo_enable_i & (|err_i[3:1]);

    always_comb
    begin
        case (adr_i)
            uart_pkg::ADR_RBR_THR_DLL : rd_byte = dlab_i ? dll_i : rx_dat_i;
            uart_pkg::ADR_IER_DLM     : rd_byte = dlab_i ? dlm_i : {5'b0, ier_i};
            uart_pkg::ADR_IIR_FCR     : rd_byte = {fifo_enable_i, fifo_enable_i, 2'b0,
                                                   intr_id_i, intr_pending_i};
            uart_pkg::ADR_LCR         : rd_byte = lcr_i;
            uart_pkg::ADR_MCR         : rd_byte = {3'b0, loop_back_i, 4'b0};
            uart_pkg::ADR_LSR         : rd_byte = {fifo_data_err, tx_logic_empty_i,
                                                   tx_storage_empty_i, err_i, rx_data_ready_i};
            uart_pkg::ADR_SCR         : rd_byte = scr_i;
            default                   : rd_byte = '0;  // Unmapped
        endcase
    end

    assign rd_dat_o = {{(`UART_RD_W-`UART_DATA_W){1'b0}}, rd_byte};

endmodule

// File: uart_line_status.sv
// Sticky line-status errors with clear-on-read
// Parity, framing and break load only on the delayed load pulse; overrun sets directly
// Load pulse trails its source by two cycles and may overlap a new one
`timescale 1ns/1ns

module uart_line_status (
    input  logic        WBs_CLK_i,
    input  logic        WBs_RST_i,
    input  logic        fifo_enable_i,
    input  logic        rx_fifo_empty_i,
    input  logic        rx_fifo_push_i,
    input  logic        rx_fifo_pop_i,
    input  logic        overrun_i,
    input  logic        parity_i,
    input  logic        framing_i,
    input  logic        break_i,
    input  logic        lsr_rd_i,
    output logic        load_o,
    output logic [3:0]  err_o,                      // {break, framing, parity, overrun}
    output logic        intr_o
);

    logic load_src;                                 // New word reaches the FIFO head
    logic load_d1;                                  // First pipeline stage

    // In FIFO mode only a head change carries new status
    assign load_src = fifo_enable_i ? ((rx_fifo_empty_i & rx_fifo_push_i)
                                     | (~rx_fifo_empty_i & rx_fifo_pop_i))
                                    : rx_fifo_push_i;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            load_d1 <= 1'b0;
            load_o  <= 1'b0;
            err_o   <= 4'b0;
        end
        else
        begin
            load_d1  <= load_src;
            load_o   <= load_d1;
            err_o[0] <= overrun_i | (err_o[0] & ~lsr_rd_i);
            // A load replaces the held value, a read clears it
            err_o[1] <= load_o ? parity_i  : (err_o[1] & ~lsr_rd_i);
            err_o[2] <= load_o ? framing_i : (err_o[2] & ~lsr_rd_i);
            err_o[3] <= load_o ? break_i   : (err_o[3] & ~lsr_rd_i);
        end
    end

    assign intr_o = |err_o;                         // Level to the interrupt controller

endmodule

// File: uart_ctrl_regs.sv
// Host-written control registers: IER, FCR, LCR, MCR, SCR, DLL, DLM
// Flush outputs are high whenever the FIFO is disabled, including after reset
// Only the loop-back bit of MCR is stored
`timescale 1ns/1ns
`include "uart_config.svh"

module uart_ctrl_regs (
    input  logic                  WBs_CLK_i,
    input  logic                  WBs_RST_i,
    input  uart_pkg::bus_data_t   dat_i,
    input  logic                  ier_wr_i,
    input  logic                  fcr_wr_i,
    input  logic                  lcr_wr_i,
    input  logic                  mcr_wr_i,
    input  logic                  scr_wr_i,
    input  logic                  dll_wr_i,
    input  logic                  dlm_wr_i,
    output logic                  dlab_o,
    output logic [2:0]            ier_o,
    output logic                  fifo_enable_o,
    output logic [1:0]            rx_trigger_o,
    output uart_pkg::bus_data_t   lcr_o,
    output logic                  loop_back_o,
    output uart_pkg::bus_data_t   scr_o,
    output uart_pkg::divisor_t    divisor_o,
    output logic                  rx_flush_o,
    output logic                  tx_flush_o
);

    localparam uart_pkg::bus_data_t IER_RST = `UART_IER_DEFAULT;
    localparam uart_pkg::bus_data_t FCR_RST = `UART_FCR_DEFAULT;
    localparam uart_pkg::bus_data_t LCR_RST = `UART_LCR_DEFAULT;
    localparam uart_pkg::bus_data_t MCR_RST = `UART_MCR_DEFAULT;
    localparam uart_pkg::bus_data_t SCR_RST = `UART_SCR_DEFAULT;
    localparam uart_pkg::bus_data_t DLL_RST = `UART_DLL_DEFAULT;
    localparam uart_pkg::bus_data_t DLM_RST = `UART_DLM_DEFAULT;

    logic                rx_rst_q;                  // Self-clearing flush requests
    logic                tx_rst_q;
    uart_pkg::bus_data_t dll_q;
    uart_pkg::bus_data_t dlm_q;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ier_o         <= IER_RST[2:0];
            fifo_enable_o <= FCR_RST[0];
            rx_trigger_o  <= FCR_RST[7:6];
            rx_rst_q      <= FCR_RST[`UART_FCR_RXRST_BIT];
            tx_rst_q      <= FCR_RST[`UART_FCR_TXRST_BIT];
            lcr_o         <= LCR_RST;
            loop_back_o   <= MCR_RST[`UART_MCR_LOOP_BIT];
            scr_o         <= SCR_RST;
            dll_q         <= DLL_RST;
            dlm_q         <= DLM_RST;
        end
        else
        begin
            if (ier_wr_i)
                ier_o <= dat_i[2:0];                // Rx data, THR empty, line status
            if (fcr_wr_i)
            begin
                fifo_enable_o <= dat_i[0];
                rx_trigger_o  <= dat_i[7:6];
            end
            // Reset bits last one cycle and are never stored
            rx_rst_q <= fcr_wr_i & dat_i[`UART_FCR_RXRST_BIT];
            tx_rst_q <= fcr_wr_i & dat_i[`UART_FCR_TXRST_BIT];
            if (lcr_wr_i)
                lcr_o <= dat_i;
            if (mcr_wr_i)
                loop_back_o <= dat_i[`UART_MCR_LOOP_BIT];
            if (scr_wr_i)
                scr_o <= dat_i;
            if (dll_wr_i)
                dll_q <= dat_i;
            if (dlm_wr_i)
                dlm_q <= dat_i;
        end
    end

    assign dlab_o     = lcr_o[`UART_LCR_DLAB_BIT];  // Banks addresses 0 and 1
    assign divisor_o  = {dlm_q, dll_q};             // Baud x16 divisor
    assign rx_flush_o = ~fifo_enable_o | rx_rst_q;
    assign tx_flush_o = ~fifo_enable_o | tx_rst_q;

endmodule

// File: uart_bus_decode.sv
// Bus acknowledge and register decode
// A held strobe is acked every other cycle; writes decode in the cycle before ACK
// Reads decode during ACK; pop, IIR-read and divisor-load are delayed one cycle
`timescale 1ns/1ns

module uart_bus_decode (
    input  logic                  WBs_CLK_i,
    input  logic                  WBs_RST_i,
    input  uart_pkg::reg_addr_e   adr_i,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic                  dlab_i,
    output logic                  ack_o,
    output logic                  thr_wr_o,
    output logic                  ier_wr_o,
    output logic                  fcr_wr_o,
    output logic                  lcr_wr_o,
    output logic                  mcr_wr_o,
    output logic                  scr_wr_o,
    output logic                  dll_wr_o,
    output logic                  dlm_wr_o,
    output logic                  lsr_rd_o,
    output logic                  rbr_pop_o,
    output logic                  iir_rd_o,
    output logic                  div_load_o
);

    logic wr_cyc;                                   // Write, before ACK
    logic rd_cyc;                                   // Read, during ACK
    logic div_wr_ack;                               // Divisor write, during ACK

    assign wr_cyc     = cyc_i & stb_i & we_i & ~ack_o;
    assign rd_cyc     = cyc_i & stb_i & ~we_i & ack_o;
    assign div_wr_ack = cyc_i & stb_i & we_i & ack_o & dlab_i
                      & ((adr_i == uart_pkg::ADR_RBR_THR_DLL) | (adr_i == uart_pkg::ADR_IER_DLM));

    // Write decodes ------------------------------------
    assign thr_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_RBR_THR_DLL) & ~dlab_i;
    assign ier_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_IER_DLM)     & ~dlab_i;
    assign dll_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_RBR_THR_DLL) &  dlab_i;
    assign dlm_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_IER_DLM)     &  dlab_i;
    assign fcr_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_IIR_FCR);   // Not banked
    assign lcr_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_LCR);
    assign mcr_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_MCR);
    assign scr_wr_o = wr_cyc & (adr_i == uart_pkg::ADR_SCR);

    assign lsr_rd_o = rd_cyc & (adr_i == uart_pkg::ADR_LSR);       // Clears sticky errors

    // ACK and delayed pulses ---------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ack_o      <= 1'b0;
            rbr_pop_o  <= 1'b0;
            iir_rd_o   <= 1'b0;
            div_load_o <= 1'b0;
        end
        else
        begin
            ack_o      <= cyc_i & stb_i & ~ack_o;                  // Drops after one cycle
            // Pop after ACK so the read data holds through the ack cycle
            rbr_pop_o  <= rd_cyc & (adr_i == uart_pkg::ADR_RBR_THR_DLL) & ~dlab_i;
            iir_rd_o   <= rd_cyc & (adr_i == uart_pkg::ADR_IIR_FCR);
            div_load_o <= div_wr_ack;                              // Divisor already updated
        end
    end

endmodule

// File: uart_pkg.sv
// Shared types for the UART register block
// Address enum covers the mapped registers only; other codes fall to the mux default
`include "uart_config.svh"

package uart_pkg;

    // Register addresses, banked ones named by all their roles
    typedef enum logic [`UART_ADDR_W-1:0] {
        ADR_RBR_THR_DLL = `UART_ADR_RBR_THR_DLL,
        ADR_IER_DLM     = `UART_ADR_IER_DLM,
        ADR_IIR_FCR     = `UART_ADR_IIR_FCR,
        ADR_LCR         = `UART_ADR_LCR,
        ADR_MCR         = `UART_ADR_MCR,
        ADR_LSR         = `UART_ADR_LSR,
        ADR_SCR         = `UART_ADR_SCR
    } reg_addr_e;

    typedef logic [`UART_DATA_W-1:0]   bus_data_t;  // One host byte
    typedef logic [`UART_RD_W-1:0]     rd_data_t;   // Read word
    typedef logic [2*`UART_DATA_W-1:0] divisor_t;   // {DLM, DLL}

endpackage

// File: uart_config.svh
// Register map constants for the 16550-style host register block
// Widths are fixed by the register map; changing them breaks the read mux layout
// Addresses 6, 8 and above are unmapped and read as zero
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Bus widths --------------------------------------
`define UART_ADDR_W             4       // Register address
`define UART_DATA_W             8       // Host write byte
`define UART_RD_W               16      // Read word, upper byte always zero

// Register addresses ------------------------------
`define UART_ADR_RBR_THR_DLL    4'h0    // DLAB selects DLL
`define UART_ADR_IER_DLM        4'h1    // DLAB selects DLM
`define UART_ADR_IIR_FCR        4'h2    // IIR on read, FCR on write
`define UART_ADR_LCR            4'h3
`define UART_ADR_MCR            4'h4
`define UART_ADR_LSR            4'h5
`define UART_ADR_SCR            4'h7

// Reset values
`define UART_IER_DEFAULT        8'h00
`define UART_FCR_DEFAULT        8'h00   // FIFO disabled, so both flushes sit high
`define UART_LCR_DEFAULT        8'h00
`define UART_MCR_DEFAULT        8'h00
`define UART_SCR_DEFAULT        8'h00
`define UART_DLL_DEFAULT        8'h00
`define UART_DLM_DEFAULT        8'h00

// Field positions
`define UART_FCR_RXRST_BIT      1       // Rx FIFO flush request
`define UART_FCR_TXRST_BIT      2       // Tx FIFO flush request
`define UART_LCR_DLAB_BIT       7       // Divisor latch access
`define UART_MCR_LOOP_BIT       4       // Loop back

`endif
